// ==== verilog/board_pkg.sv ====
// Board-wide constants for reset, LED and input polarity
// Joystick and status word bit positions
// Joystick and DIP setting struct types
package board_pkg;

    // Reset stretch after the last cause clears
    localparam int RST_CYCLES = 16;
    localparam int RST_CNT_W  = $clog2(RST_CYCLES + 1);

    typedef logic [RST_CNT_W-1:0] rst_cnt_t;

    localparam rst_cnt_t RST_LOAD = rst_cnt_t'(RST_CYCLES);

    // LED toggles every 2**(BLINK_BITS-1) clocks while downloading
    localparam int BLINK_BITS = 4;

    // Game side polarity and button count
    localparam logic GAME_INPUTS_ACTIVE_LOW = 1'b1;
    localparam int   BUTTONS                = 6;
    localparam int   JOY_W                  = BUTTONS + 4;

    localparam logic [JOY_W-1:0] JOY_INV = {JOY_W{GAME_INPUTS_ACTIVE_LOW}};
    localparam logic [3:0]       BTN_INV = {4{GAME_INPUTS_ACTIVE_LOW}};

    // Special bits in board joystick 1
    localparam int JOY_PAUSE_BIT   = 10;
    localparam int JOY_RESET_BIT   = 11;
    localparam int JOY_SERVICE_BIT = 12;

    // Status word fields
    localparam int ST_ROTATE_LSB = 1;
    localparam int ST_FLIP       = 3;
    localparam int ST_FM_OFF     = 4;
    localparam int ST_PSG_OFF    = 5;
    localparam int ST_TEST       = 6;
    localparam int ST_OSD_PAUSE  = 7;
    localparam int ST_FX_LSB     = 8;
    localparam int ST_AUTOFIRE   = 18;

    typedef logic [15:0] board_joy_t;

    // Same bit order as the game joystick word, right at bit 0
    typedef struct packed {
        logic [BUTTONS-1:0] buttons;
        logic               up;
        logic               down;
        logic               left;
        logic               right;
    } joy_t;

    typedef struct packed {
        logic [1:0] rotate;
        logic       enable_fm;
        logic       enable_psg;
        logic       dip_test;
        logic       dip_flip;
        logic [1:0] dip_fxlevel;
    } dip_settings_t;

endpackage

// ==== verilog/board_reset.sv ====
// Reset sequencer for the system and game resets
// Both resets stretch a fixed count after their last cause
`timescale 1ns/100ps

module board_reset (
    input  logic clk_sys,
    input  logic arst_n,
    input  logic pll_locked,
    input  logic rst_req,
    input  logic downloading,
    input  logic soft_rst,
    output logic rst,
    output logic game_rst
);

    // Index 0 is the system reset, index 1 the game reset
    logic [1:0]          cause;
    board_pkg::rst_cnt_t cnt [2];

    assign cause[0] = ~pll_locked | rst_req;
    // Game reset also covers ROM download and the in-game reset
    assign cause[1] = cause[0] | downloading | soft_rst;

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            cnt[0] <= board_pkg::RST_LOAD;
            cnt[1] <= board_pkg::RST_LOAD;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (cause[i]) begin
                    cnt[i] <= board_pkg::RST_LOAD;
                end else if (cnt[i] != '0) begin
                    cnt[i] <= cnt[i] - 1'b1;
                end
            end
        end
    end

    // Held while the stretch count runs
    assign rst      = cnt[0] != '0;
    assign game_rst = cnt[1] != '0;

endmodule

// ==== verilog/dip_decoder.sv ====
// Registered decoding of the OSD status word
// DIP settings and the combined pause output
`timescale 1ns/100ps

module dip_decoder (
    input  logic                     clk_sys,
    input  logic                     arst_n,
    input  logic [63:0]              status,
    input  logic                     osd_shown,
    input  logic                     game_pause,
    output board_pkg::dip_settings_t dip,
    output logic                     dip_pause
);

    logic osd_pause;

    // Pause while the menu is up, if the user asked for it
    assign osd_pause = osd_shown & status[board_pkg::ST_OSD_PAUSE];

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            dip       <= '0;
            dip_pause <= 1'b1;
        end else begin
            dip.rotate      <= status[board_pkg::ST_ROTATE_LSB +: 2];
            // Status bits disable the chips, the outputs enable them
            dip.enable_fm   <= ~status[board_pkg::ST_FM_OFF];
            dip.enable_psg  <= ~status[board_pkg::ST_PSG_OFF];
            dip.dip_test    <= status[board_pkg::ST_TEST];
            dip.dip_flip    <= status[board_pkg::ST_FLIP];
            dip.dip_fxlevel <= status[board_pkg::ST_FX_LSB +: 2];
            // Low means paused
            dip_pause       <= ~(game_pause | osd_pause);
        end
    end

endmodule

// ==== verilog/input_mapper.sv ====
// Board to game input mapping with polarity conversion
// Pause toggle, soft reset pulse and button 0 autofire
`timescale 1ns/100ps

module input_mapper (
    input  logic                          clk_sys,
    input  logic                          arst_n,
    input  logic                          vs,
    input  logic [63:0]                   status,
    input  board_pkg::board_joy_t [3:0]   board_joy,
    input  logic [3:0]                    board_start,
    input  logic [3:0]                    board_coin,
    output board_pkg::joy_t [3:0]         game_joy,
    output logic [3:0]                    game_start,
    output logic [3:0]                    game_coin,
    output logic                          game_service,
    output logic                          game_pause,
    output logic                          soft_rst
);

    board_pkg::joy_t [3:0] joy_raw;
    board_pkg::joy_t       p1_raw;
    logic                  pause_bit;
    logic                  reset_bit;
    logic                  pause_l;
    logic                  reset_l;
    logic                  vs_l;
    logic                  af_on;
    logic                  af_active;
    logic                  af_phase;

    assign p1_raw    = board_pkg::joy_t'(board_joy[0][board_pkg::JOY_W-1:0]);
    assign pause_bit = board_joy[0][board_pkg::JOY_PAUSE_BIT];
    assign reset_bit = board_joy[0][board_pkg::JOY_RESET_BIT];
    assign af_on     = status[board_pkg::ST_AUTOFIRE];
    assign af_active = af_on & p1_raw.buttons[0];

    // Active-high board words, upper bits dropped
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            joy_raw[i] = board_pkg::joy_t'(board_joy[i][board_pkg::JOY_W-1:0]);
        end
        // Autofire masks button 0 in the low phase
        joy_raw[0].buttons[0] = p1_raw.buttons[0] & (~af_on | af_phase);
    end

    // Autofire phase advances once per frame
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            vs_l     <= 1'b0;
            af_phase <= 1'b1;
        end else begin
            vs_l <= vs;
            if (!af_active) begin
                af_phase <= 1'b1;
            end else if (vs && !vs_l) begin
                af_phase <= ~af_phase;
            end
        end
    end

    // Pause and reset bits act on their rising edges only
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            pause_l    <= 1'b0;
            reset_l    <= 1'b0;
            game_pause <= 1'b0;
            soft_rst   <= 1'b0;
        end else begin
            pause_l  <= pause_bit;
            reset_l  <= reset_bit;
            soft_rst <= reset_bit & ~reset_l;
            if (pause_bit && !pause_l) begin
                game_pause <= ~game_pause;
            end
        end
    end

    // Game side outputs, inactive level out of reset
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 4; i++) begin
                game_joy[i] <= board_pkg::joy_t'(board_pkg::JOY_INV);
            end
            game_start   <= board_pkg::BTN_INV;
            game_coin    <= board_pkg::BTN_INV;
            game_service <= board_pkg::GAME_INPUTS_ACTIVE_LOW;
        end else begin
            for (int i = 0; i < 4; i++) begin
                game_joy[i] <= board_pkg::joy_t'(joy_raw[i] ^ board_pkg::JOY_INV);
            end
            game_start   <= board_start ^ board_pkg::BTN_INV;
            game_coin    <= board_coin ^ board_pkg::BTN_INV;
            game_service <= board_joy[0][board_pkg::JOY_SERVICE_BIT]
                            ^ board_pkg::GAME_INPUTS_ACTIVE_LOW;
        end
    end

endmodule

// ==== verilog/led_driver.sv ====
// Status LED with the download blink counter
`timescale 1ns/100ps

module led_driver (
    input  logic       clk_sys,
    input  logic       arst_n,
    input  logic       downloading,
    input  logic       osd_shown,
    input  logic [1:0] game_led,
    output logic       led
);

    logic [board_pkg::BLINK_BITS-1:0] blink_cnt;

    // Free running, top bit sets the blink rate
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            blink_cnt <= '0;
        end else begin
            blink_cnt <= blink_cnt + 1'b1;
        end
    end

    // Download blink first, then OSD, then the game's own LED
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            led <= 1'b0;
        end else if (downloading) begin
            led <= blink_cnt[board_pkg::BLINK_BITS-1];
        end else if (osd_shown) begin
            led <= 1'b1;
        end else begin
            led <= game_led[0];
        end
    end

endmodule

// ==== verilog/game_board.sv ====
// Board control top level
// Reset sequencer, input mapper, DIP decoder and LED driver
`timescale 1ns/100ps

module game_board (
    input  logic                        clk_sys,
    input  logic                        arst_n,
    input  logic                        pll_locked,
    input  logic                        rst_req,
    input  logic                        downloading,
    input  logic                        vs,
    input  logic                        osd_shown,
    input  logic [63:0]                 status,
    input  logic [1:0]                  game_led,
    input  board_pkg::board_joy_t [3:0] board_joy,
    input  logic [3:0]                  board_start,
    input  logic [3:0]                  board_coin,
    output logic                        rst,
    output logic                        game_rst,
    output board_pkg::joy_t [3:0]       game_joy,
    output logic [3:0]                  game_start,
    output logic [3:0]                  game_coin,
    output logic                        game_service,
    output board_pkg::dip_settings_t    dip,
    output logic                        dip_pause,
    output logic                        led
);

    logic soft_rst;
    logic game_pause;

    board_reset u_reset (
        .clk_sys     ( clk_sys     ),
        .arst_n      ( arst_n      ),
        .pll_locked  ( pll_locked  ),
        .rst_req     ( rst_req     ),
        .downloading ( downloading ),
        .soft_rst    ( soft_rst    ),
        .rst         ( rst         ),
        .game_rst    ( game_rst    )
    );

    input_mapper u_inputs (
        .clk_sys      ( clk_sys      ),
        .arst_n       ( arst_n       ),
        .vs           ( vs           ),
        .status       ( status       ),
        .board_joy    ( board_joy    ),
        .board_start  ( board_start  ),
        .board_coin   ( board_coin   ),
        .game_joy     ( game_joy     ),
        .game_start   ( game_start   ),
        .game_coin    ( game_coin    ),
        .game_service ( game_service ),
        .game_pause   ( game_pause   ),
        .soft_rst     ( soft_rst     )
    );

    dip_decoder u_dip (
        .clk_sys    ( clk_sys    ),
        .arst_n     ( arst_n     ),
        .status     ( status     ),
        .osd_shown  ( osd_shown  ),
        .game_pause ( game_pause ),
        .dip        ( dip        ),
        .dip_pause  ( dip_pause  )
    );

    led_driver u_led (
        .clk_sys     ( clk_sys     ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .osd_shown   ( osd_shown   ),
        .game_led    ( game_led    ),
        .led         ( led         )
    );

endmodule

// ==== tests/board_assertions.sv ====
// Concurrent checks on the reset outputs, soft reset and pause
`timescale 1ns/100ps

module board_assertions (
    input logic clk_sys,
    input logic arst_n,
    input logic rst,
    input logic game_rst,
    input logic soft_rst,
    input logic dip_pause
);

    // Game reset covers every system reset cause
    rst_covered: assert property (
        @(posedge clk_sys) disable iff (!arst_n) rst |-> game_rst
    ) else $error("game_rst low while rst is high");

    // Not paused on the first edge out of reset
    pause_after_reset: assert property (
        @(posedge clk_sys) $rose(arst_n) |-> dip_pause
    ) else $error("dip_pause low right after reset");

    soft_rst_pulse: assert property (
        @(posedge clk_sys) disable iff (!arst_n) $rose(soft_rst) |=> !soft_rst
    ) else $error("soft_rst held longer than one cycle");

endmodule

bind game_board board_assertions u_assertions (.*);

// ==== tests/tb_game_board.sv ====
// Testbench for the board control top level
// Reset release, input and DIP table, pause, soft reset, autofire and LED
`timescale 1ns/100ps

module tb_game_board;

    localparam int PERIOD       = 8;
    localparam int NUM_ROWS     = 12;
    localparam int RESET_HOLD   = 4;
    localparam int BLINK_WINDOW = 64;
    // Reset releases, blink window, table and the short directed sections
    localparam int TEST_CYCLES  = NUM_ROWS + RESET_HOLD + BLINK_WINDOW
                                  + 4 * board_pkg::RST_CYCLES + 40;

    typedef struct packed {
        board_pkg::board_joy_t [3:0]    joy;
        logic [3:0]                     start;
        logic [3:0]                     coin;
        logic [63:0]                    status;
        logic                           osd;
        board_pkg::joy_t [3:0]          exp_joy;
        logic [3:0]                     exp_start;
        logic [3:0]                     exp_coin;
        logic                           exp_service;
        board_pkg::dip_settings_t       exp_dip;
    } vec_t;

    logic                        clk_sys;
    logic                        arst_n;
    logic                        pll_locked;
    logic                        rst_req;
    logic                        downloading;
    logic                        vs;
    logic                        osd_shown;
    logic [63:0]                 status;
    logic [1:0]                  game_led;
    board_pkg::board_joy_t [3:0] board_joy;
    logic [3:0]                  board_start;
    logic [3:0]                  board_coin;
    logic                        rst;
    logic                        game_rst;
    board_pkg::joy_t [3:0]       game_joy;
    logic [3:0]                  game_start;
    logic [3:0]                  game_coin;
    logic                        game_service;
    board_pkg::dip_settings_t    dip;
    logic                        dip_pause;
    logic                        led;

    vec_t rows [NUM_ROWS];

    game_board uut (.*);

    initial begin
        clk_sys = 1'b0;
        forever #(PERIOD / 2) clk_sys = ~clk_sys;
    end

    initial begin
        #(TEST_CYCLES * PERIOD * 4);
        $display("Timeout: the run did not finish within %0d cycles", TEST_CYCLES * 4);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %b expected %b", what, got, exp));
        end
    endtask

    task automatic check_nibble(input string what, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
        end
    endtask

    task automatic check_joy(input string what, input board_pkg::joy_t got,
                             input board_pkg::joy_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
        end
    endtask

    task automatic check_dip(input string what, input board_pkg::dip_settings_t got,
                             input board_pkg::dip_settings_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
        end
    endtask

    task automatic step(input int n);
        repeat (n) @(negedge clk_sys);
    endtask

    // Counter reaches one after RST_CYCLES-1 edges, zero on the next
    task automatic expect_release(input logic sys_exp);
        step(board_pkg::RST_CYCLES - 1);
        check_bit("rst before release", rst, sys_exp);
        check_bit("game_rst before release", game_rst, 1'b1);
        step(1);
        check_bit("rst after release", rst, 1'b0);
        check_bit("game_rst after release", game_rst, 1'b0);
    endtask

    function automatic board_pkg::dip_settings_t expect_dip(input logic [63:0] st);
        board_pkg::dip_settings_t d;
        d.rotate      = st[board_pkg::ST_ROTATE_LSB +: 2];
        d.enable_fm   = ~st[board_pkg::ST_FM_OFF];
        d.enable_psg  = ~st[board_pkg::ST_PSG_OFF];
        d.dip_test    = st[board_pkg::ST_TEST];
        d.dip_flip    = st[board_pkg::ST_FLIP];
        d.dip_fxlevel = st[board_pkg::ST_FX_LSB +: 2];
        return d;
    endfunction

    initial begin
        vec_t            v;
        board_pkg::joy_t held;
        int              toggles;
        logic            led_prev;
        logic            pressed;

        void'($urandom(32'h899a));
        arst_n      = 1'b0;
        pll_locked  = 1'b1;
        rst_req     = 1'b0;
        downloading = 1'b0;
        vs          = 1'b0;
        osd_shown   = 1'b0;
        status      = '0;
        game_led    = '0;
        board_joy   = '0;
        board_start = '0;
        board_coin  = '0;

        // Stimulus table, first rows with chosen status words
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int i = 0; i < 4; i++) begin
                v.joy[i] = 16'($urandom);
            end
            // Keep pause and reset edges out of the table
            v.joy[0][board_pkg::JOY_PAUSE_BIT] = 1'b0;
            v.joy[0][board_pkg::JOY_RESET_BIT] = 1'b0;
            v.start  = 4'($urandom);
            v.coin   = 4'($urandom);
            v.osd    = 1'($urandom);
            case (r)
                0:       v.status = 64'h0;
                1:       v.status = 64'h3fe;
                2:       v.status = 64'h152;
                3:       v.status = 64'h2a8;
                default: v.status = {$urandom, $urandom};
            endcase
            v.status[board_pkg::ST_AUTOFIRE] = 1'b0;
            for (int i = 0; i < 4; i++) begin
                v.exp_joy[i] = board_pkg::joy_t'(~v.joy[i][board_pkg::JOY_W-1:0]);
            end
            v.exp_start   = ~v.start;
            v.exp_coin    = ~v.coin;
            v.exp_service = ~v.joy[0][board_pkg::JOY_SERVICE_BIT];
            v.exp_dip     = expect_dip(v.status);
            rows[r]       = v;
        end

        step(RESET_HOLD);
        check_bit("dip_pause in reset", dip_pause, 1'b1);
        arst_n = 1'b1;
        expect_release(1'b1);

        for (int r = 0; r < NUM_ROWS; r++) begin
            board_joy   = rows[r].joy;
            board_start = rows[r].start;
            board_coin  = rows[r].coin;
            status      = rows[r].status;
            osd_shown   = rows[r].osd;
            step(1);
            for (int i = 0; i < 4; i++) begin
                check_joy($sformatf("game_joy[%0d] row %0d", i, r), game_joy[i],
                          rows[r].exp_joy[i]);
            end
            check_nibble("game_start", game_start, rows[r].exp_start);
            check_nibble("game_coin", game_coin, rows[r].exp_coin);
            check_bit("game_service", game_service, rows[r].exp_service);
            check_dip($sformatf("dip row %0d", r), dip, rows[r].exp_dip);
        end
        board_joy = '0;
        status    = '0;
        osd_shown = 1'b0;
        step(2);

        // Download holds game reset and blinks the LED
        downloading = 1'b1;
        step(1);
        check_bit("game_rst while downloading", game_rst, 1'b1);
        check_bit("rst while downloading", rst, 1'b0);
        toggles = 0;
        for (int c = 0; c < BLINK_WINDOW; c++) begin
            led_prev = led;
            step(1);
            if (led !== led_prev) begin
                toggles++;
            end
        end
        if (toggles != BLINK_WINDOW / 8) begin
            report_mismatch($sformatf("led toggled %0d times during download", toggles));
        end
        downloading = 1'b0;
        expect_release(1'b0);

        // Pause toggles on each press of the pause bit
        check_bit("dip_pause idle", dip_pause, 1'b1);
        board_joy[0][board_pkg::JOY_PAUSE_BIT] = 1'b1;
        step(2);
        check_bit("dip_pause after first press", dip_pause, 1'b0);
        board_joy[0][board_pkg::JOY_PAUSE_BIT] = 1'b0;
        step(2);
        check_bit("dip_pause after release", dip_pause, 1'b0);
        board_joy[0][board_pkg::JOY_PAUSE_BIT] = 1'b1;
        step(2);
        check_bit("dip_pause after second press", dip_pause, 1'b1);
        board_joy[0][board_pkg::JOY_PAUSE_BIT] = 1'b0;
        status[board_pkg::ST_OSD_PAUSE] = 1'b1;
        osd_shown = 1'b1;
        step(1);
        check_bit("dip_pause with OSD", dip_pause, 1'b0);
        check_bit("led with OSD", led, 1'b1);
        osd_shown = 1'b0;
        game_led  = 2'b01;
        step(1);
        check_bit("dip_pause after OSD", dip_pause, 1'b1);
        check_bit("led from game_led", led, 1'b1);
        game_led = 2'b10;
        step(1);
        check_bit("led ignores game_led[1]", led, 1'b0);
        status = '0;

        // Soft reset reaches game_rst two cycles after the edge
        board_joy[0][board_pkg::JOY_RESET_BIT] = 1'b1;
        step(1);
        check_bit("game_rst before soft reset", game_rst, 1'b0);
        step(1);
        check_bit("game_rst on soft reset", game_rst, 1'b1);
        check_bit("rst on soft reset", rst, 1'b0);
        board_joy[0][board_pkg::JOY_RESET_BIT] = 1'b0;
        expect_release(1'b0);

        // Autofire alternates button 0 on each frame
        held            = '0;
        held.buttons[0] = 1'b1;
        board_joy[0]    = 16'(held);
        status[board_pkg::ST_AUTOFIRE] = 1'b1;
        step(1);
        pressed = 1'b1;
        for (int k = 0; k < 6; k++) begin
            check_bit("autofire button 0", game_joy[0].buttons[0], ~pressed);
            if (k == 3) begin
                status[board_pkg::ST_AUTOFIRE] = 1'b0;
            end
            vs = 1'b1;
            step(1);
            vs = 1'b0;
            step(1);
            pressed = (k >= 3) ? 1'b1 : ~pressed;
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== tb.f ====
verilog/board_pkg.sv
verilog/board_reset.sv
verilog/dip_decoder.sv
verilog/input_mapper.sv
verilog/led_driver.sv
verilog/game_board.sv
tests/board_assertions.sv
tests/tb_game_board.sv

// ==== Makefile ====
SRCS := $(shell cat tb.f)
BIN  := obj_dir/Vtb_game_board

.PHONY: all run clean

all: run

$(BIN): $(SRCS) tb.f
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_game_board

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
